/* Makefile */
VERILATOR ?= verilator
TOP       ?= simt_core_tb
FILE_LIST ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* compile.f */
+incdir+.
simt_pkg.sv
lane_issue_if.sv
store_req_if.sv
issue_scheduler.sv
simt_lane.sv
store_drain.sv
simt_core.sv
simt_core_tb.sv

/* issue_scheduler.sv */
`timescale 1ns/100ps

`include "simt_defs.svh"

module issue_scheduler (
    input  logic                           clk,
    input  logic                           reset,

    input  logic                           start,
    input  logic [2:0]                     active_warps,
    output logic                           done,

    output logic                           instr_read_valid,
    output simt_pkg::iaddr_t               instr_read_address,
    input  logic                           instr_read_ready,
    input  logic [`SIMT_INSTR_WIDTH-1:0]   instr_read_data,

    input  logic                           store_busy,

    lane_issue_if.scheduler                issue
);
    import simt_pkg::*;

    sched_state_t state;
    warp_state_t  warp_state [`SIMT_NUM_WARPS];
    iaddr_t       pc         [`SIMT_NUM_WARPS];
    lane_mask_t   warp_mask  [`SIMT_NUM_WARPS];

    warp_id_t cur_warp;
    // First warp the next round-robin search looks at
    warp_id_t base_warp;
    logic [`SIMT_INSTR_WIDTH-1:0] instr_word;

    logic     pick_found;
    warp_id_t pick_warp;
    opcode_t  cur_op;

    // Round-robin search over active warps starting at base_warp
    always_comb begin
        warp_id_t idx;
        pick_found = 1'b0;
        pick_warp  = base_warp;
        for (int k = 0; k < `SIMT_NUM_WARPS; k++) begin
            idx = base_warp + warp_id_t'(k);
            if (!pick_found && warp_state[idx] == WARP_ACTIVE) begin
                pick_found = 1'b1;
                pick_warp  = idx;
            end
        end
    end

    // Decode of the fetched word
    assign cur_op        = opcode_t'(instr_word[`SIMT_OPCODE_RANGE]);
    assign issue.opcode  = cur_op;
    assign issue.rd      = instr_word[`SIMT_RD_RANGE];
    assign issue.rs1     = instr_word[`SIMT_RS1_RANGE];
    assign issue.rs2     = instr_word[`SIMT_RS2_RANGE];
    assign issue.imm     = {{(`SIMT_DATA_WIDTH - `SIMT_IMM_WIDTH){instr_word[`SIMT_IMM_WIDTH-1]}},
                            instr_word[`SIMT_IMM_RANGE]};
    assign issue.warp_id   = cur_warp;
    assign issue.lane_mask = warp_mask[cur_warp];

    // Mask and halt stay inside the scheduler
    assign issue.issue_valid = (state == SCHED_ISSUE) && (cur_op != OP_MASK) &&
                               (cur_op != OP_HALT);

    assign instr_read_valid   = (state == SCHED_FETCH);
    assign instr_read_address = pc[cur_warp];

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= SCHED_IDLE;
            done      <= 1'b0;
            cur_warp  <= '0;
            base_warp <= '0;
            for (int i = 0; i < `SIMT_NUM_WARPS; i++) begin
                warp_state[i] <= WARP_IDLE;
                pc[i]         <= '0;
                warp_mask[i]  <= '1;
            end
        end else begin
            case (state)
                SCHED_IDLE: begin
                    if (start) begin
                        done      <= 1'b0;
                        cur_warp  <= '0;
                        base_warp <= '0;
                        state     <= SCHED_SELECT;
                        for (int i = 0; i < `SIMT_NUM_WARPS; i++) begin
                            warp_state[i] <= (3'(i) < active_warps) ? WARP_ACTIVE : WARP_IDLE;
                            pc[i]         <= '0;
                            warp_mask[i]  <= '1;
                        end
                    end
                end
                SCHED_SELECT: begin
                    if (pick_found) begin
                        cur_warp <= pick_warp;
                        state    <= SCHED_FETCH;
                    end else begin
                        // Every warp has halted
                        done  <= 1'b1;
                        state <= SCHED_IDLE;
                    end
                end
                SCHED_FETCH: begin
                    if (instr_read_ready) begin
                        instr_word <= instr_read_data;
                        state      <= SCHED_ISSUE;
                    end
                end
                SCHED_ISSUE: begin
                    pc[cur_warp] <= pc[cur_warp] + iaddr_t'(1);
                    base_warp    <= cur_warp + warp_id_t'(1);
                    if (cur_op == OP_MASK)
                        warp_mask[cur_warp] <= issue.imm[`SIMT_NUM_LANES-1:0];
                    if (cur_op == OP_HALT)
                        warp_state[cur_warp] <= WARP_DONE;
                    state <= (cur_op == OP_STORE) ? SCHED_DRAIN : SCHED_SELECT;
                end
                SCHED_DRAIN: begin
                    // Lanes raised req at the end of issue
                    if (!store_busy)
                        state <= SCHED_SELECT;
                end
                default: state <= SCHED_IDLE;
            endcase
        end
    end

endmodule

/* lane_issue_if.sv */
`timescale 1ns/100ps

// Decoded instruction broadcast from the scheduler to every lane
interface lane_issue_if;
    import simt_pkg::*;

    logic       issue_valid;
    opcode_t    opcode;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    data_t      imm;
    warp_id_t   warp_id;
    lane_mask_t lane_mask;

    modport scheduler (
        output issue_valid, opcode, rd, rs1, rs2, imm, warp_id, lane_mask
    );

    modport lane (
        input issue_valid, opcode, rd, rs1, rs2, imm, warp_id, lane_mask
    );

endinterface

/* simt_core.sv */
`timescale 1ns/100ps

`include "simt_defs.svh"

module simt_core (
    input  logic                           clk,
    input  logic                           reset,

    input  logic                           start,
    input  logic [2:0]                     active_warps,
    output logic                           done,

    // Instruction read port
    output logic                           instr_read_valid,
    output simt_pkg::iaddr_t               instr_read_address,
    input  logic                           instr_read_ready,
    input  logic [`SIMT_INSTR_WIDTH-1:0]   instr_read_data,

    // Data write port
    output logic                           data_write_valid,
    output simt_pkg::daddr_t               data_write_address,
    output simt_pkg::data_t                data_write_data,
    input  logic                           data_write_ready
);

    logic store_busy;

    lane_issue_if issue_bus ();
    store_req_if  store_bus [`SIMT_NUM_LANES] ();

    issue_scheduler scheduler_inst (
        .clk                (clk),
        .reset              (reset),
        .start              (start),
        .active_warps       (active_warps),
        .done               (done),
        .instr_read_valid   (instr_read_valid),
        .instr_read_address (instr_read_address),
        .instr_read_ready   (instr_read_ready),
        .instr_read_data    (instr_read_data),
        .store_busy         (store_busy),
        .issue              (issue_bus.scheduler)
    );

    for (genvar g = 0; g < `SIMT_NUM_LANES; g++) begin : g_lane
        simt_lane #(
            .LANE_INDEX (g)
        ) lane_inst (
            .clk   (clk),
            .reset (reset),
            .issue (issue_bus.lane),
            .store (store_bus[g].lane)
        );
    end

    store_drain drain_inst (
        .clk                (clk),
        .reset              (reset),
        .stores             (store_bus),
        .data_write_valid   (data_write_valid),
        .data_write_address (data_write_address),
        .data_write_data    (data_write_data),
        .data_write_ready   (data_write_ready),
        .store_busy         (store_busy)
    );

endmodule

/* simt_core_tb.sv */
`timescale 1ns/100ps

`include "simt_defs.svh"

module simt_core_tb;

    localparam int IMEM_DEPTH   = 1 << `SIMT_IADDR_WIDTH;
    localparam int RESET_CYCLES = 16;
    localparam int WAIT_LIMIT   = 2000;
    localparam int HOLD_CYCLES  = 20;

    logic                         clk;
    logic                         reset;
    logic                         start;
    logic [2:0]                   active_warps;
    logic                         done;
    logic                         instr_read_valid;
    logic [`SIMT_IADDR_WIDTH-1:0] instr_read_address;
    logic                         instr_read_ready;
    logic [`SIMT_INSTR_WIDTH-1:0] instr_read_data;
    logic                         data_write_valid;
    logic [`SIMT_DADDR_WIDTH-1:0] data_write_address;
    logic [`SIMT_DATA_WIDTH-1:0]  data_write_data;
    logic                         data_write_ready;

    logic [`SIMT_INSTR_WIDTH-1:0] imem [IMEM_DEPTH];
    int                           run_warps [$];
    int                           run_counts [$];
    logic [`SIMT_DADDR_WIDTH-1:0] exp_addr [$];
    logic [`SIMT_DATA_WIDTH-1:0]  exp_data [$];
    logic [`SIMT_DADDR_WIDTH-1:0] got_addr [$];
    logic [`SIMT_DATA_WIDTH-1:0]  got_data [$];

    logic [31:0] rng = 32'hac62;
    // Wait cycles left for the pending fetch or -1 when none
    int          fetch_wait = -1;

    simt_core simt_core_inst (
        .clk                (clk),
        .reset              (reset),
        .start              (start),
        .active_warps       (active_warps),
        .done               (done),
        .instr_read_valid   (instr_read_valid),
        .instr_read_address (instr_read_address),
        .instr_read_ready   (instr_read_ready),
        .instr_read_data    (instr_read_data),
        .data_write_valid   (data_write_valid),
        .data_write_address (data_write_address),
        .data_write_data    (data_write_data),
        .data_write_ready   (data_write_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_failure();
        $display("Simulation finished: FAIL");
        $fatal(1, "Test stopped at the first error");
    endtask

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s got %h, expected %h", $time, what, actual, expected);
            report_failure();
        end
    endtask

    task automatic load_golden();
        int          fd;
        string       line;
        byte         kind;
        int          warps;
        logic [31:0] rec_addr;
        logic [31:0] rec_word;
        // Unused locations hold a no-op with the address in its low bits
        for (int a = 0; a < IMEM_DEPTH; a++)
            imem[a] = {4'hf, 20'h0, 8'(a)};
        fd = $fopen("simt_golden.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the golden file simt_golden.txt");
            report_failure();
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0)
                break;
            kind = line.getc(0);
            if (kind == "I") begin
                if ($sscanf(line, "I %h %h", rec_addr, rec_word) != 2) begin
                    $display("Malformed instruction record in golden file: %s", line);
                    report_failure();
                end
                imem[rec_addr[`SIMT_IADDR_WIDTH-1:0]] = rec_word;
            end else if (kind == "R") begin
                if ($sscanf(line, "R %d", warps) != 1) begin
                    $display("Malformed run record in golden file: %s", line);
                    report_failure();
                end
                run_warps.push_back(warps);
                run_counts.push_back(0);
            end else if (kind == "S") begin
                if (run_counts.size() == 0 ||
                    $sscanf(line, "S %h %h", rec_addr, rec_word) != 2) begin
                    $display("Store record without a run or malformed: %s", line);
                    report_failure();
                end
                exp_addr.push_back(rec_addr[`SIMT_DADDR_WIDTH-1:0]);
                exp_data.push_back(rec_word);
                run_counts[run_counts.size()-1] = run_counts[run_counts.size()-1] + 1;
            end
        end
        $fclose(fd);
        if (run_warps.size() == 0) begin
            $display("The golden file holds no run record");
            report_failure();
        end
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            #1;
            check_equal(32'(done), 32'd0, "done in reset");
            check_equal(32'(instr_read_valid), 32'd0, "instr_read_valid in reset");
            check_equal(32'(data_write_valid), 32'd0, "data_write_valid in reset");
        end
        reset = 1'b0;
    endtask

    task automatic wait_for_store();
        int cycles;
        cycles = 0;
        while (got_addr.size() == 0) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("Timeout while waiting for a store on the data write port");
                report_failure();
            end
        end
    endtask

    task automatic wait_for_done();
        int cycles;
        cycles = 0;
        while (done !== 1'b1) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("Timeout while waiting for done after the last store");
                report_failure();
            end
        end
    endtask

    // Fetch answers after 0 to 3 wait cycles and write ready drops at random
    always @(posedge clk) begin
        #1;
        rng = xorshift32(rng);
        data_write_ready = (rng[1:0] != 2'b00);
        instr_read_ready = 1'b0;
        if (!instr_read_valid) begin
            fetch_wait = -1;
        end else begin
            if (fetch_wait < 0)
                fetch_wait = int'(rng[5:4]);
            if (fetch_wait == 0) begin
                instr_read_ready = 1'b1;
                instr_read_data  = imem[instr_read_address];
                fetch_wait       = -1;
            end else begin
                fetch_wait--;
            end
        end
    end

    // Transfer completes at the next rising edge
    always @(negedge clk) begin
        if (!reset && data_write_valid && data_write_ready) begin
            check_equal(32'(done), 32'd0, "done while a store is pending");
            got_addr.push_back(data_write_address);
            got_data.push_back(data_write_data);
        end
    end

    initial begin
        int                           exp_idx;
        logic [`SIMT_DADDR_WIDTH-1:0] addr;
        logic [`SIMT_DATA_WIDTH-1:0]  data;
        reset            = 1'b1;
        start            = 1'b0;
        active_warps     = 3'd0;
        instr_read_ready = 1'b0;
        instr_read_data  = '0;
        data_write_ready = 1'b0;
        load_golden();
        exp_idx = 0;
        for (int r = 0; r < run_warps.size(); r++) begin
            apply_reset();
            active_warps = 3'(run_warps[r]);
            // One idle cycle out of reset before start
            @(posedge clk);
            #1;
            check_equal(32'(done), 32'd0, "done after reset");
            check_equal(32'(instr_read_valid), 32'd0, "instr_read_valid after reset");
            check_equal(32'(data_write_valid), 32'd0, "data_write_valid after reset");
            start = 1'b1;
            @(posedge clk);
            #1;
            start = 1'b0;
            for (int s = 0; s < run_counts[r]; s++) begin
                wait_for_store();
                addr = got_addr.pop_front();
                data = got_data.pop_front();
                check_equal(32'(addr), 32'(exp_addr[exp_idx]),
                            $sformatf("run %0d store %0d address", r, s));
                check_equal(data, exp_data[exp_idx], $sformatf("run %0d store %0d data", r, s));
                exp_idx++;
            end
            wait_for_done();
            // Done holds with no further stores
            for (int k = 0; k < HOLD_CYCLES; k++) begin
                @(posedge clk);
                #1;
                check_equal(32'(done), 32'd1, "done after halt");
            end
            check_equal(32'(got_addr.size()), 32'd0, "stores after done");
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* simt_defs.svh */
`ifndef SIMT_DEFS_SVH
`define SIMT_DEFS_SVH

// Core sizes
`define SIMT_NUM_WARPS      4
`define SIMT_NUM_LANES      4
`define SIMT_DATA_WIDTH     32
`define SIMT_REG_COUNT      16
`define SIMT_IADDR_WIDTH    8
`define SIMT_DADDR_WIDTH    16
`define SIMT_INSTR_WIDTH    32

// Instruction word fields
`define SIMT_OPCODE_RANGE   31:28
`define SIMT_RD_RANGE       27:24
`define SIMT_RS1_RANGE      23:20
`define SIMT_RS2_RANGE      19:16
`define SIMT_IMM_RANGE      15:0
`define SIMT_IMM_WIDTH      16

`endif

/* simt_golden.txt */
# I <instr address hex> <instr word hex>   program image
# R <active_warps decimal>                  new run after reset
# S <data address hex> <data word hex>      expected stores of the run, in order
I 00 51000000 # LANEID r1
I 01 42100100 # ADDI r2, r1, 0x100
I 02 4500fff0 # ADDI r5, r0, -16
I 03 03120000 # ADD r3, r1, r2
I 04 14150000 # SUB r4, r1, r5
I 05 26350000 # AND r6, r3, r5
I 06 37430000 # XOR r7, r4, r3
I 07 70000005 # MASK lanes 0 and 2
I 08 60160200 # STORE [r1 + 0x200] = r6
I 09 7000000f # MASK all lanes
I 0a 60170300 # STORE [r1 + 0x300] = r7
I 0b 80000000 # HALT
R 4
S 0200 00000100
S 0202 00000100
S 0204 00000100
S 0206 00000100
S 0208 00000110
S 020a 00000110
S 020c 00000110
S 020e 00000110
S 0300 00000110
S 0301 00000113
S 0302 00000116
S 0303 00000115
S 0304 0000011c
S 0305 0000011f
S 0306 0000011a
S 0307 00000119
S 0308 00000108
S 0309 0000010b
S 030a 0000010e
S 030b 0000010d
S 030c 00000104
S 030d 00000107
S 030e 00000102
S 030f 00000101
R 2
S 0200 00000100
S 0202 00000100
S 0204 00000100
S 0206 00000100
S 0300 00000110
S 0301 00000113
S 0302 00000116
S 0303 00000115
S 0304 0000011c
S 0305 0000011f
S 0306 0000011a
S 0307 00000119

/* simt_lane.sv */
`timescale 1ns/100ps

`include "simt_defs.svh"

module simt_lane #(
    parameter int LANE_INDEX = 0
) (
    input  logic        clk,
    input  logic        reset,
    lane_issue_if.lane  issue,
    store_req_if.lane   store
);
    import simt_pkg::*;

    // One register bank per warp
    data_t regs [`SIMT_NUM_WARPS][`SIMT_REG_COUNT];

    data_t rs1_val;
    data_t rs2_val;
    data_t alu_result;
    logic  lane_on;
    logic  write_en;

    assign rs1_val = regs[issue.warp_id][issue.rs1];
    assign rs2_val = regs[issue.warp_id][issue.rs2];
    assign lane_on = issue.issue_valid && issue.lane_mask[LANE_INDEX];

    always_comb begin
        write_en   = 1'b1;
        alu_result = '0;
        case (issue.opcode)
            OP_ADD:    alu_result = rs1_val + rs2_val;
            OP_SUB:    alu_result = rs1_val - rs2_val;
            OP_AND:    alu_result = rs1_val & rs2_val;
            OP_XOR:    alu_result = rs1_val ^ rs2_val;
            OP_ADDI:   alu_result = rs1_val + issue.imm;
            OP_LANEID: alu_result = data_t'(issue.warp_id) * data_t'(`SIMT_NUM_LANES) +
                                    data_t'(LANE_INDEX);
            default:   write_en   = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < `SIMT_NUM_WARPS; w++) begin
                for (int r = 0; r < `SIMT_REG_COUNT; r++) begin
                    regs[w][r] <= '0;
                end
            end
        end else if (lane_on && write_en) begin
            regs[issue.warp_id][issue.rd] <= alu_result;
        end
    end

    // Store request held until the drain unit acks it
    always_ff @(posedge clk) begin
        if (reset) begin
            store.req <= 1'b0;
        end else if (lane_on && issue.opcode == OP_STORE) begin
            store.req <= 1'b1;
        end else if (store.ack) begin
            store.req <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (lane_on && issue.opcode == OP_STORE) begin
            store.address <= daddr_t'(rs1_val + issue.imm);
            store.data    <= rs2_val;
        end
    end

endmodule

/* simt_pkg.sv */
`include "simt_defs.svh"

package simt_pkg;

    typedef enum logic [3:0] {
        OP_ADD    = 4'h0,
        OP_SUB    = 4'h1,
        OP_AND    = 4'h2,
        OP_XOR    = 4'h3,
        OP_ADDI   = 4'h4,
        OP_LANEID = 4'h5,
        OP_STORE  = 4'h6,
        OP_MASK   = 4'h7,
        OP_HALT   = 4'h8
    } opcode_t;

    typedef enum logic [1:0] {
        WARP_IDLE,
        WARP_ACTIVE,
        WARP_DONE
    } warp_state_t;

    typedef enum logic [2:0] {
        SCHED_IDLE,
        SCHED_SELECT,
        SCHED_FETCH,
        SCHED_ISSUE,
        SCHED_DRAIN
    } sched_state_t;

    typedef logic [`SIMT_DATA_WIDTH-1:0]             data_t;
    typedef logic [`SIMT_IADDR_WIDTH-1:0]            iaddr_t;
    typedef logic [`SIMT_DADDR_WIDTH-1:0]            daddr_t;
    typedef logic [$clog2(`SIMT_REG_COUNT)-1:0]      reg_addr_t;
    typedef logic [$clog2(`SIMT_NUM_WARPS)-1:0]      warp_id_t;
    typedef logic [`SIMT_NUM_LANES-1:0]              lane_mask_t;

endpackage

/* store_drain.sv */
`timescale 1ns/100ps

`include "simt_defs.svh"

module store_drain (
    input  logic              clk,
    input  logic              reset,
    store_req_if.drain        stores [`SIMT_NUM_LANES],
    output logic              data_write_valid,
    output simt_pkg::daddr_t  data_write_address,
    output simt_pkg::data_t   data_write_data,
    input  logic              data_write_ready,
    output logic              store_busy
);
    import simt_pkg::*;

    localparam int LANE_BITS = $clog2(`SIMT_NUM_LANES);

    lane_mask_t           req_vec;
    lane_mask_t           ack_vec;
    daddr_t               addr_arr [`SIMT_NUM_LANES];
    data_t                data_arr [`SIMT_NUM_LANES];
    logic [LANE_BITS-1:0] low_sel;
    logic [LANE_BITS-1:0] sel;
    logic [LANE_BITS-1:0] locked_sel;
    logic                 locked;

    for (genvar g = 0; g < `SIMT_NUM_LANES; g++) begin : g_port
        assign req_vec[g]     = stores[g].req;
        assign addr_arr[g]    = stores[g].address;
        assign data_arr[g]    = stores[g].data;
        assign stores[g].ack  = ack_vec[g];
        assign ack_vec[g]     = data_write_valid && data_write_ready && (sel == LANE_BITS'(g));
    end

    // Lowest lane index with a pending request wins
    always_comb begin
        low_sel = '0;
        for (int i = `SIMT_NUM_LANES - 1; i >= 0; i--) begin
            if (req_vec[i])
                low_sel = LANE_BITS'(i);
        end
    end

    // A stalled transfer keeps its lane until ready
    assign sel                = locked ? locked_sel : low_sel;
    assign data_write_valid   = req_vec[sel];
    assign data_write_address = addr_arr[sel];
    assign data_write_data    = data_arr[sel];
    assign store_busy         = |req_vec;

    always_ff @(posedge clk) begin
        if (reset) begin
            locked <= 1'b0;
        end else begin
            locked <= data_write_valid && !data_write_ready;
        end
    end

    always_ff @(posedge clk) begin
        locked_sel <= sel;
    end

endmodule

/* store_req_if.sv */
`timescale 1ns/100ps

// One lane's pending store, held until the drain unit acks it
interface store_req_if;
    import simt_pkg::*;

    logic   req;
    daddr_t address;
    data_t  data;
    logic   ack;

    modport lane (output req, address, data, input ack);

    modport drain (input req, address, data, output ack);

endinterface
